//--- Makefile
# Verilator build and run of the dual-clock FWFT FIFO testbench
# The binary is rebuilt only when a source or the file list changes

SRCS := $(filter-out +%,$(shell cat files.f)) src/fifo_cfg.svh

.PHONY: all run clean

all: run

obj_dir/VfwftFifo_tb: files.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module fwftFifo_tb -f files.f

run: obj_dir/VfwftFifo_tb
	obj_dir/VfwftFifo_tb

clean:
	rm -rf obj_dir

//--- files.f
+incdir+src
src/fifo_pkg.sv
src/fifoRam.sv
src/fifoWrCtrl.sv
src/fifoRdCtrl.sv
src/asyncFifo.sv
src/fwftStage.sv
src/fwftFifo.sv
tests/fwftFifo_assert.sv
tests/fwftFifo_tb.sv

//--- src/asyncFifo.sv
// --------------------------------------------------
// Standard-mode async FIFO core
// Read data shows up one RD_CLK after coreRdEn
// --------------------------------------------------
`timescale 1ns/1ps
`include "fifo_cfg.svh"

module asyncFifo (
	input  logic                WR_CLK,
	input  logic                WR_RST,
	input  logic                RD_CLK,
	input  logic                RD_RST,
	input  fifo_pkg::fifoData_t wrData,
	input  logic                wrEn,
	output logic                wrFull,
	input  logic                coreRdEn,
	output fifo_pkg::fifoData_t coreData,
	output logic                coreEmpty
);

	logic [`FIFO_ADDR_BITS-1:0] ramWrAddr;
	logic [`FIFO_ADDR_BITS-1:0] ramRdAddr;
	logic                       ramWrEn;
	logic                       ramRdEn;
	logic [`FIFO_ADDR_BITS:0]   wrPtrGray; // Crosses into RD_CLK
	logic [`FIFO_ADDR_BITS:0]   rdPtrGray; // Crosses into WR_CLK

	fifoRam uRam (
		.WR_CLK    (WR_CLK),
		.RD_CLK    (RD_CLK),
		.ramWrEn   (ramWrEn),
		.ramWrAddr (ramWrAddr),
		.ramRdAddr (ramRdAddr),
		.ramWrData (wrData),
		.ramRdEn   (ramRdEn),
		.ramRdData (coreData)
	);

	fifoWrCtrl uWrCtrl (
		.WR_CLK    (WR_CLK),
		.WR_RST    (WR_RST),
		.wrEn      (wrEn),
		.rdPtrGray (rdPtrGray),
		.wrPtrGray (wrPtrGray),
		.ramWrAddr (ramWrAddr),
		.ramWrEn   (ramWrEn),
		.wrFull    (wrFull)
	);

	fifoRdCtrl uRdCtrl (
		.RD_CLK    (RD_CLK),
		.RD_RST    (RD_RST),
		.rdEn      (coreRdEn),
		.wrPtrGray (wrPtrGray),
		.rdPtrGray (rdPtrGray),
		.ramRdAddr (ramRdAddr),
		.ramRdEn   (ramRdEn),
		.rdEmpty   (coreEmpty)
	);

endmodule

//--- src/fifoRam.sv
// --------------------------------------------------
// Simple dual-port RAM for the async FIFO core
// Write on WR_CLK, registered read on RD_CLK
// --------------------------------------------------
`timescale 1ns/1ps
`include "fifo_cfg.svh"

module fifoRam (
	input  logic                       WR_CLK,
	input  logic                       RD_CLK,
	input  logic                       ramWrEn,
	input  logic [`FIFO_ADDR_BITS-1:0] ramWrAddr,
	input  logic [`FIFO_ADDR_BITS-1:0] ramRdAddr,
	input  fifo_pkg::fifoData_t        ramWrData,
	input  logic                       ramRdEn,
	output fifo_pkg::fifoData_t        ramRdData
);
	import fifo_pkg::*;

	fifoData_t mem [0:`FIFO_DEPTH-1]; // Storage, no reset

	// Write port
	always_ff @(posedge WR_CLK) begin
		if (ramWrEn) begin
			mem[ramWrAddr] <= ramWrData;
		end
	end

	// Read port, data valid one RD_CLK after ramRdEn
	always_ff @(posedge RD_CLK) begin
		if (ramRdEn) begin
			ramRdData <= mem[ramRdAddr];
		end
	end

endmodule

//--- src/fifoRdCtrl.sv
// --------------------------------------------------
// Read side of the async FIFO core
// Read pointer, write pointer sync and empty flag
// --------------------------------------------------
`timescale 1ns/1ps
`include "fifo_cfg.svh"

module fifoRdCtrl (
	input  logic                       RD_CLK,
	input  logic                       RD_RST,
	input  logic                       rdEn,
	input  logic [`FIFO_ADDR_BITS:0]   wrPtrGray,
	output logic [`FIFO_ADDR_BITS:0]   rdPtrGray,
	output logic [`FIFO_ADDR_BITS-1:0] ramRdAddr,
	output logic                       ramRdEn,
	output logic                       rdEmpty
);

	logic [`FIFO_ADDR_BITS:0] rdBin;      // Binary read pointer
	logic [`FIFO_ADDR_BITS:0] rdBinNext;
	logic [`FIFO_ADDR_BITS:0] rdGrayNext;
	logic [`FIFO_ADDR_BITS:0] wrSync1;    // Write pointer, first sync flop
	logic [`FIFO_ADDR_BITS:0] wrSync2;    // Write pointer, safe to use
	logic                     rdAccept;

	assign rdAccept   = rdEn & ~rdEmpty; // Reads while empty are ignored
	assign rdBinNext  = rdBin + {{`FIFO_ADDR_BITS{1'b0}}, rdAccept};
	assign rdGrayNext = (rdBinNext >> 1) ^ rdBinNext;
	assign ramRdAddr  = rdBin[`FIFO_ADDR_BITS-1:0];
	assign ramRdEn    = rdAccept;        // RAM output updates only on a read

	// --------------------------------------------------
	// Pointers and empty flag
	always_ff @(posedge RD_CLK) begin
		if (RD_RST) begin
			rdBin     <= '0;
			rdPtrGray <= '0;
			wrSync1   <= '0;
			wrSync2   <= '0;
			rdEmpty   <= 1'b1; // Empty out of reset
		end else begin
			rdBin     <= rdBinNext;
			rdPtrGray <= rdGrayNext;
			wrSync1   <= wrPtrGray; // Two-flop sync from WR_CLK
			wrSync2   <= wrSync1;
			rdEmpty   <= (rdGrayNext == wrSync2); // Caught up with writer
		end
	end

endmodule

//--- src/fifoWrCtrl.sv
// --------------------------------------------------
// Write side of the async FIFO core
// Write pointer, read pointer sync and full flag
// --------------------------------------------------
`timescale 1ns/1ps
`include "fifo_cfg.svh"

module fifoWrCtrl (
	input  logic                       WR_CLK,
	input  logic                       WR_RST,
	input  logic                       wrEn,
	input  logic [`FIFO_ADDR_BITS:0]   rdPtrGray,
	output logic [`FIFO_ADDR_BITS:0]   wrPtrGray,
	output logic [`FIFO_ADDR_BITS-1:0] ramWrAddr,
	output logic                       ramWrEn,
	output logic                       wrFull
);

	logic [`FIFO_ADDR_BITS:0] wrBin;      // Binary write pointer
	logic [`FIFO_ADDR_BITS:0] wrBinNext;
	logic [`FIFO_ADDR_BITS:0] wrGrayNext;
	logic [`FIFO_ADDR_BITS:0] rdSync1;    // Read pointer, first sync flop
	logic [`FIFO_ADDR_BITS:0] rdSync2;    // Read pointer, safe to use
	logic                     wrAccept;

	assign wrAccept   = wrEn & ~wrFull;  // Writes while full are dropped
	assign wrBinNext  = wrBin + {{`FIFO_ADDR_BITS{1'b0}}, wrAccept};
	assign wrGrayNext = (wrBinNext >> 1) ^ wrBinNext;
	assign ramWrAddr  = wrBin[`FIFO_ADDR_BITS-1:0];
	assign ramWrEn    = wrAccept;

	// --------------------------------------------------
	// Pointers and full flag
	always_ff @(posedge WR_CLK) begin
		if (WR_RST) begin
			wrBin     <= '0;
			wrPtrGray <= '0;
			rdSync1   <= '0;
			rdSync2   <= '0;
			wrFull    <= 1'b0;
		end else begin
			wrBin     <= wrBinNext;
			wrPtrGray <= wrGrayNext;
			rdSync1   <= rdPtrGray; // Two-flop sync from RD_CLK
			rdSync2   <= rdSync1;
			// Full when a whole depth ahead, top two Gray bits flipped
			wrFull    <= (wrGrayNext == {~rdSync2[`FIFO_ADDR_BITS:`FIFO_ADDR_BITS-1],
				rdSync2[`FIFO_ADDR_BITS-2:0]});
		end
	end

endmodule

//--- src/fifo_cfg.svh
// --------------------------------------------------
// Build-time sizing of the dual-clock FWFT FIFO
// Include wherever width, depth or pointer size is needed
// --------------------------------------------------
`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

`define FIFO_WIDTH     32 // Data word bits
`define FIFO_DEPTH     16 // Core RAM words, power of two only
`define FIFO_ADDR_BITS 4  // log2 of depth

// Pointers carry one extra wrap bit on top of the address
`endif

//--- src/fifo_pkg.sv
// --------------------------------------------------
// Shared types of the FWFT FIFO
// Modules import it inside their body where needed
// --------------------------------------------------
`include "fifo_cfg.svh"

package fifo_pkg;

	typedef logic [`FIFO_WIDTH-1:0] fifoData_t; // One FIFO word

	// Prefetch stage occupancy
	typedef enum logic [1:0] {
		FWFT_IDLE = 2'd0, // Nothing held
		FWFT_OUT  = 2'd1, // Output register loaded
		FWFT_FULL = 2'd2  // Output register and cache loaded
	} fwftState_t;

endpackage

//--- src/fwftFifo.sv
// --------------------------------------------------
// Dual-clock first-word-fall-through FIFO, top level
// Head word is on rdData whenever rdEmpty is low
// --------------------------------------------------
`timescale 1ns/1ps

module fwftFifo (
	input  logic                WR_CLK,
	input  logic                WR_RST,
	input  logic                RD_CLK,
	input  logic                RD_RST,
	input  fifo_pkg::fifoData_t wrData,
	input  logic                wrEn,
	output logic                wrFull,
	output fifo_pkg::fifoData_t rdData,
	input  logic                rdEn,
	output logic                rdEmpty
);
	import fifo_pkg::*;

	fifoData_t coreData;  // Core read port, one cycle latency
	logic      coreRdEn;
	logic      coreEmpty;

	asyncFifo uCore (
		.WR_CLK    (WR_CLK),
		.WR_RST    (WR_RST),
		.RD_CLK    (RD_CLK),
		.RD_RST    (RD_RST),
		.wrData    (wrData),
		.wrEn      (wrEn),
		.wrFull    (wrFull),
		.coreRdEn  (coreRdEn),
		.coreData  (coreData),
		.coreEmpty (coreEmpty)
	);

	fwftStage uFwft (
		.RD_CLK    (RD_CLK),
		.RD_RST    (RD_RST),
		.coreData  (coreData),
		.coreEmpty (coreEmpty),
		.coreRdEn  (coreRdEn),
		.rdEn      (rdEn),
		.rdData    (rdData),
		.rdEmpty   (rdEmpty)
	);

endmodule

//--- src/fwftStage.sv
// --------------------------------------------------
// Prefetch stage turning the core into FWFT
// Output register plus one cache word, one word per cycle
// --------------------------------------------------
`timescale 1ns/1ps

module fwftStage (
	input  logic                RD_CLK,
	input  logic                RD_RST,
	input  fifo_pkg::fifoData_t coreData,
	input  logic                coreEmpty,
	output logic                coreRdEn,
	input  logic                rdEn,
	output fifo_pkg::fifoData_t rdData,
	output logic                rdEmpty
);
	import fifo_pkg::*;

	fwftState_t state;
	fwftState_t stateNext;
	fifoData_t  outReg;       // Head word seen on rdData
	fifoData_t  cacheReg;     // Next word behind the head
	logic [1:0] count;        // Held words plus reads in flight
	logic       inFlight;     // Core word lands on coreData this cycle
	logic       outValid;
	logic       pop;
	logic       loadOutCore;  // Core word into output register
	logic       loadOutCache; // Cached word into output register
	logic       loadCache;    // Core word into cache

	assign outValid = (state != FWFT_IDLE);
	assign pop      = rdEn & outValid; // Pops while empty do nothing
	assign rdData   = outReg;
	assign rdEmpty  = ~outValid;

	// Keep the pipe topped up, replace each word that leaves
	assign coreRdEn = ((count < 2'd2) | pop) & ~coreEmpty;

	// --------------------------------------------------
	// Occupancy tracking
	always_ff @(posedge RD_CLK) begin
		if (RD_RST) begin
			count    <= 2'd0;
			inFlight <= 1'b0;
			state    <= FWFT_IDLE;
		end else begin
			count    <= count + {1'b0, coreRdEn} - {1'b0, pop};
			inFlight <= coreRdEn; // Core data valid next cycle
			state    <= stateNext;
		end
	end

	// --------------------------------------------------
	// Where the returning and cached words go
	always_comb begin
		stateNext    = state;
		loadOutCore  = 1'b0;
		loadOutCache = 1'b0;
		loadCache    = 1'b0;
		case (state)
			FWFT_IDLE: begin
				if (inFlight) begin
					loadOutCore = 1'b1; // Falls straight through
					stateNext   = FWFT_OUT;
				end
			end
			FWFT_OUT: begin
				if (inFlight && pop) begin
					loadOutCore = 1'b1; // Replace the popped head
				end else if (inFlight) begin
					loadCache = 1'b1;
					stateNext = FWFT_FULL;
				end else if (pop) begin
					stateNext = FWFT_IDLE;
				end
			end
			FWFT_FULL: begin
				if (pop) begin
					loadOutCache = 1'b1; // Cache moves up
					loadCache    = inFlight;
					if (!inFlight) begin
						stateNext = FWFT_OUT;
					end
				end
			end
			default: stateNext = FWFT_IDLE;
		endcase
	end

	// Payload registers
	always_ff @(posedge RD_CLK) begin
		if (loadOutCore) begin
			outReg <= coreData;
		end else if (loadOutCache) begin
			outReg <= cacheReg;
		end
		if (loadCache) begin
			cacheReg <= coreData;
		end
	end

endmodule

//--- tests/fwftFifo_assert.sv
// --------------------------------------------------
// Concurrent checks bound into the FIFO core and the prefetch stage
// One checker module per bind target
// --------------------------------------------------
`timescale 1ns/1ps
`include "fifo_cfg.svh"

module asyncFifoAssert (
	input logic                     WR_CLK,
	input logic                     WR_RST,
	input logic                     RD_CLK,
	input logic                     RD_RST,
	input logic                     ramRdEn,   // Core read taken this edge
	input logic [`FIFO_ADDR_BITS:0] wrPtrGray,
	input logic [`FIFO_ADDR_BITS:0] rdPtrGray
);

	// Never read past the live write pointer
	noReadPastWriter: assert property (@(posedge RD_CLK) disable iff (RD_RST)
		ramRdEn |-> (rdPtrGray != wrPtrGray)) else $error("core read taken while empty");

	// Gray pointers step one bit at a time
	wrGrayStep: assert property (@(posedge WR_CLK) disable iff (WR_RST)
		$countones(wrPtrGray ^ $past(wrPtrGray)) <= 1) else $error("write Gray jump");
	rdGrayStep: assert property (@(posedge RD_CLK) disable iff (RD_RST)
		$countones(rdPtrGray ^ $past(rdPtrGray)) <= 1) else $error("read Gray jump");

endmodule

module fwftStageAssert (
	input logic                 RD_CLK,
	input logic                 RD_RST,
	input logic [1:0]           count,    // Held words plus reads in flight
	input logic                 inFlight, // Core word landing this cycle
	input fifo_pkg::fwftState_t state
);
	import fifo_pkg::*;

	logic [1:0] heldWords; // Words in output register and cache

	assign heldWords = (state == FWFT_FULL) ? 2'd2 : ((state == FWFT_OUT) ? 2'd1 : 2'd0);

	// Count stays in step with the registers and the pipe
	countTracks: assert property (@(posedge RD_CLK) disable iff (RD_RST)
		count == heldWords + {1'b0, inFlight}) else $error("stage count out of step");

	// Both registers loaded, no core word may arrive
	noWordWhenFull: assert property (@(posedge RD_CLK) disable iff (RD_RST)
		(state == FWFT_FULL) |-> !inFlight) else $error("core word with stage full");

endmodule

bind asyncFifo asyncFifoAssert uCoreChk (
	.WR_CLK    (WR_CLK),
	.WR_RST    (WR_RST),
	.RD_CLK    (RD_CLK),
	.RD_RST    (RD_RST),
	.ramRdEn   (ramRdEn),
	.wrPtrGray (wrPtrGray),
	.rdPtrGray (rdPtrGray)
);

bind fwftStage fwftStageAssert uStageChk (
	.RD_CLK   (RD_CLK),
	.RD_RST   (RD_RST),
	.count    (count),
	.inFlight (inFlight),
	.state    (state)
);

//--- tests/fwftFifo_tb.sv
// --------------------------------------------------
// Testbench for the dual-clock FWFT FIFO
// Runs a table of phases against a queue model of accepted words
// --------------------------------------------------
`timescale 1ns/1ps
`include "fifo_cfg.svh"

module fwftFifo_tb;
	import fifo_pkg::*;

	// One stimulus row, -1 skips that check
	typedef struct packed {
		int wrCount;  // wrEn strobes
		int wrGap;    // Idle WR cycles, percent
		int rdCount;  // rdEn strobes
		int rdDuty;   // RD cycles with rdEn, percent
		int settle;   // RD cycles allowed for the flags
		int expFull;
		int expEmpty;
		int expAcc;   // Accepted writes in the phase
		int expLevel; // Model words left
		int drain;    // rdEmpty must track the model level
	} phase_t;

	localparam int NumPhases = 8;

	logic        WR_CLK;
	logic        WR_RST;
	logic        RD_CLK;
	logic        RD_RST;
	fifoData_t   wrData;
	fifoData_t   rdData;
	logic        wrEn;
	logic        wrFull;
	logic        rdEn;
	logic        rdEmpty;
	phase_t      phases [0:NumPhases-1];
	fifoData_t   model [$];   // Accepted words, oldest first
	int          accepted;
	int          cycleCount;
	int          cycleLimit;
	logic        drainMode;

	fwftFifo uut (
		.WR_CLK (WR_CLK), .WR_RST (WR_RST), .RD_CLK (RD_CLK), .RD_RST (RD_RST),
		.wrData (wrData), .wrEn (wrEn), .wrFull (wrFull),
		.rdData (rdData), .rdEn (rdEn), .rdEmpty (rdEmpty)
	);

	initial begin
		RD_CLK = 1'b0;
		forever #5 RD_CLK = ~RD_CLK;
	end

	initial begin
		WR_CLK = 1'b0;
		#2.5;            // Keeps WR edges off every RD event
		forever #7 WR_CLK = ~WR_CLK;
	end

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("Testbench failed");
			$fatal(1, "Value mismatch");
		end
	endtask

	function automatic bit flagsOk(input int expFull, input int expEmpty);
		return ((expFull < 0) || (int'(wrFull) == expFull)) &&
			((expEmpty < 0) || (int'(rdEmpty) == expEmpty));
	endfunction

	task automatic driveWrites(input int count, input int gapPct);
		int done;
		done = 0;
		while (done < count) begin
			@(posedge WR_CLK);
			#1;
			if (int'($urandom_range(99)) < gapPct) begin
				wrEn = 1'b0;
			end else begin
				wrEn   = 1'b1;
				wrData = $urandom;
				done++;
			end
		end
		@(posedge WR_CLK);
		#1;
		wrEn = 1'b0;
	endtask

	task automatic driveReads(input int count, input int duty);
		int done;
		done = 0;
		while (done < count) begin
			@(posedge RD_CLK);
			#1;
			rdEn = (int'($urandom_range(99)) < duty);
			if (rdEn) done++;
		end
		@(posedge RD_CLK);
		#1;
		rdEn = 1'b0;
	endtask

	task automatic runPhase(input phase_t ph);
		int startAcc;
		int n;
		startAcc  = accepted;
		drainMode = (ph.drain != 0);
		fork
			driveWrites(ph.wrCount, ph.wrGap);
			driveReads(ph.rdCount, ph.rdDuty);
		join
		n = 0;
		while (n < ph.settle && !flagsOk(ph.expFull, ph.expEmpty)) begin
			@(posedge RD_CLK);
			#2;           // Both flags stable here
			n++;
		end
		if (ph.expFull >= 0) checkValue(32'(wrFull), ph.expFull, "wrFull after phase");
		if (ph.expEmpty >= 0) checkValue(32'(rdEmpty), ph.expEmpty, "rdEmpty after phase");
		drainMode = 1'b0;
		if (ph.expAcc >= 0) checkValue(accepted - startAcc, ph.expAcc, "accepted writes");
		if (ph.expLevel >= 0) checkValue(model.size(), ph.expLevel, "model level");
	endtask

	// --------------------------------------------------
	// Model and monitors
	always @(negedge WR_CLK) begin
		if (!WR_RST && wrEn && !wrFull) begin
			model.push_back(wrData); // RAM takes it at the next edge
			accepted++;
		end
	end

	always @(negedge RD_CLK) begin
		if (!RD_RST) begin
			if (drainMode) checkValue(32'(rdEmpty), 32'(model.size() == 0), "rdEmpty vs model");
			if (!rdEmpty) begin
				checkValue(32'(model.size() != 0), 32'd1, "word shown with model empty");
				checkValue(rdData, model[0], "rdData vs model head");
				if (rdEn) void'(model.pop_front()); // Pop at next edge
			end
		end
	end

	always @(posedge RD_CLK) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: no finish within %0d RD_CLK cycles", cycleLimit);
			$display("Testbench failed");
			$fatal(1, "Watchdog expired");
		end
	end

	// --------------------------------------------------
	// Main sequence
	initial begin
		int total;
		void'($urandom(32'hf46f_1a5d));
		WR_RST     = 1'b1;
		RD_RST     = 1'b1;
		wrEn       = 1'b0;
		rdEn       = 1'b0;
		wrData     = '0;
		drainMode  = 1'b0;
		accepted   = 0;
		cycleCount = 0;
		// wrN gap rdN duty settle full empty acc level drain
		phases[0] = '{1, 0, 0, 0, 8, 0, 0, 1, 1, 0};     // One word falls through
		phases[1] = '{0, 0, 1, 100, 16, 0, 1, 0, 0, 1};
		phases[2] = '{2, 0, 0, 0, 16, 0, 0, 2, 2, 0};    // Prime both stage registers
		phases[3] = '{30, 0, 0, 0, 16, 1, 0, `FIFO_DEPTH, `FIFO_DEPTH + 2, 0};
		phases[4] = '{0, 0, 22, 100, 16, 0, 1, 0, 0, 1}; // Drain plus empty pops
		phases[5] = '{60, 30, 80, 60, 16, -1, -1, -1, -1, 0};
		phases[6] = '{60, 0, 60, 30, 16, -1, -1, -1, -1, 0};
		phases[7] = '{0, 0, 60, 100, 16, 0, 1, 0, 0, 0};
		total = 0;
		for (int i = 0; i < NumPhases; i++) begin
			total += phases[i].wrCount + phases[i].rdCount + phases[i].settle;
		end
		cycleLimit = 4 * total + 200;
		fork
			begin
				repeat (10) @(posedge WR_CLK);
				#1 WR_RST = 1'b0;
			end
			begin
				repeat (10) @(posedge RD_CLK);
				#1 RD_RST = 1'b0;
			end
		join
		@(posedge RD_CLK);
		#2;
		checkValue(32'(rdEmpty), 32'd1, "rdEmpty after reset");
		checkValue(32'(wrFull), 32'd0, "wrFull after reset");
		for (int i = 0; i < NumPhases; i++) begin
			runPhase(phases[i]);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule
